// ==== Makefile ====
# Verilator build and run of the mul32 testbench

TOP = tb_mul32

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/mul_checks.svh ====
// reference model, full 64-bit unsigned product
function automatic logic [PROD_W-1:0] ref_product(input operand_t op_a, input operand_t op_b);
    logic [PROD_W-1:0] wide_a;
    logic [PROD_W-1:0] wide_b;
    wide_a = {{OP_W{1'b0}}, op_a};
    wide_b = {{OP_W{1'b0}}, op_b};
    return wide_a * wide_b;
endfunction

// one half of the product, hi or lo
task automatic check_product(input string name, input half_t got, input half_t exp);
    check_count++;
    if (got !== exp)
    begin
        $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
        test_errors++;
    end
endtask

task automatic check_valid(input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        $display("[FAIL] out_valid: got %h, expected %h at %0t", got, exp, $time);
        test_errors++;
    end
endtask

// oldest queue entry is the one leaving the pipeline this cycle
task automatic check_outputs(input logic exp_valid, input logic [PROD_W-1:0] exp_prod);
    check_valid(out_valid, exp_valid);
    if (exp_valid)
    begin
        check_product("hi", hi, exp_prod[PROD_W-1:OP_W]);
        check_product("lo", lo, exp_prod[OP_W-1:0]);
    end
endtask

// ==== bench/tb_mul32.sv ====
`timescale 1ns/1ps

module tb_mul32;
    import mul_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    // items in flight between drive and check, one per register stage
    localparam int PIPE_DEPTH   = 3;
    localparam int NUM_CORNERS  = 6;
    localparam int RANDOM_COUNT = 2000;
    localparam int GAP_COUNT    = 600;
    localparam int CARRY_COUNT  = 500;
    localparam int NUM_TESTS    = 5;
    localparam int MARGIN       = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CORNERS * NUM_CORNERS
                                   + RANDOM_COUNT + GAP_COUNT + CARRY_COUNT
                                   + NUM_TESTS * PIPE_DEPTH + MARGIN;

    typedef struct packed {
        logic              valid;
        logic [PROD_W-1:0] prod;
    } expect_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    half_t    hi;
    half_t    lo;

    expect_t     expect_q [$];
    int          test_errors;
    int          total_errors;
    int          check_count;
    int          tests_run;
    int          tests_failed;

    `include "mul_checks.svh"

    mul32 UUT (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .a(a),
        .b(b),
        .out_valid(out_valid),
        .hi(hi),
        .lo(lo)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // check what leaves the pipeline, then drive the next item 1 ns after the edge
    task automatic run_cycle(input logic valid, input operand_t op_a, input operand_t op_b);
        expect_t entry;
        @(posedge clk);
        #1;
        entry = expect_q.pop_front();
        check_outputs(entry.valid, entry.prod);
        in_valid = valid;
        a = op_a;
        b = op_b;
        // an item taken in under reset never comes out
        entry.valid = valid && !rst;
        entry.prod = ref_product(op_a, op_b);
        expect_q.push_back(entry);
    endtask

    task automatic start_test();
        test_errors = 0;
    endtask

    // idle cycles drain the pipeline so every item of the test is checked
    task automatic finish_test(input string name, input int items);
        repeat (PIPE_DEPTH) run_cycle(1'b0, '0, '0);
        $display("test %-16s %0d items, %0d errors", name, items, test_errors);
        tests_run++;
        if (test_errors > 0)
        begin
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    // in_valid stays high under reset, the last reset cycle goes idle
    task automatic test_reset();
        start_test();
        repeat (RESET_CYCLES - 1) run_cycle(1'b1, $urandom, $urandom);
        run_cycle(1'b0, '0, '0);
        rst = 1'b0;
        finish_test("reset", RESET_CYCLES);
    endtask

    task automatic test_corners();
        operand_t corners [NUM_CORNERS];
        corners[0] = 32'h0000_0000;
        corners[1] = 32'h0000_0001;
        corners[2] = 32'hFFFF_FFFF;
        corners[3] = 32'h8000_0000;
        corners[4] = 32'h7FFF_FFFF;
        corners[5] = 32'h0001_0000;
        start_test();
        for (int i = 0; i < NUM_CORNERS; i++)
        begin
            for (int j = 0; j < NUM_CORNERS; j++)
            begin
                run_cycle(1'b1, corners[i], corners[j]);
            end
        end
        finish_test("corner_operands", NUM_CORNERS * NUM_CORNERS);
    endtask

    task automatic test_random_stream();
        start_test();
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            run_cycle(1'b1, $urandom, $urandom);
        end
        finish_test("random_stream", RANDOM_COUNT);
    endtask

    // data keeps moving on idle cycles, only valid marks real items
    task automatic test_valid_gaps();
        logic valid;
        start_test();
        for (int i = 0; i < GAP_COUNT; i++)
        begin
            valid = (($urandom % 3) != 0);
            run_cycle(valid, $urandom, $urandom);
        end
        finish_test("valid_gaps", GAP_COUNT);
    endtask

    // both operands in the upper half, so the low-half add often carries into hi
    task automatic test_carry();
        operand_t op_a;
        operand_t op_b;
        start_test();
        for (int i = 0; i < CARRY_COUNT; i++)
        begin
            op_a = 32'h8000_0000 | $urandom;
            op_b = 32'h8000_0000 | $urandom;
            run_cycle(1'b1, op_a, op_b);
        end
        finish_test("carry_halves", CARRY_COUNT);
    endtask

    initial
    begin
        expect_t idle;
        rst = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        test_errors = 0;
        total_errors = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(98));
        idle.valid = 1'b0;
        idle.prod = '0;
        // reset clears every valid register, so the first outputs are idle
        repeat (PIPE_DEPTH) expect_q.push_back(idle);

        test_reset();
        test_corners();
        test_random_stream();
        test_valid_gaps();
        test_carry();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, total_errors);
        if (total_errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/dadda_stage.sv ====
`timescale 1ns/1ps

module dadda_stage #(
    parameter int TARGET = 2
) (
    input  mul_pkg::col_matrix_t cols_in,
    output mul_pkg::col_matrix_t cols_out
);
    import mul_pkg::*;

    // what one column sees and does in this step
    typedef struct packed {
        int height;
        int cin;
        int nfa;
        int nha;
    } col_plan_t;

    // replays all earlier steps from the AND array heights, so the
    // result matches the column contents arriving at this step
    function automatic col_plan_t reduce_plan(int target, int col);
        int h [NUM_COLS];
        int cin;
        int excess;
        int nfa;
        int nha;
        col_plan_t plan;
        plan = '0;
        for (int w = 0; w < NUM_COLS; w++)
        begin
            h[w] = (w < OP_W) ? w + 1 : PROD_W - 1 - w;
        end
        for (int s = 0; s < NUM_STAGES; s++)
        begin
            if (DADDA_HEIGHTS[s] >= target)
            begin
                cin = 0;
                for (int w = 0; w < NUM_COLS; w++)
                begin
                    // each full adder removes two bits, a half adder one
                    excess = h[w] + cin - DADDA_HEIGHTS[s];
                    nfa = (excess > 0) ? excess / 2 : 0;
                    nha = (excess > 0) ? excess % 2 : 0;
                    if (DADDA_HEIGHTS[s] == target && w == col)
                    begin
                        plan.height = h[w];
                        plan.cin    = cin;
                        plan.nfa    = nfa;
                        plan.nha    = nha;
                    end
                    h[w] = h[w] + cin - 2 * nfa - nha;
                    cin  = nfa + nha;
                end
            end
        end
        return plan;
    endfunction

    for (genvar w = 0; w < NUM_COLS; w++)
    begin : g_col
        localparam col_plan_t PLAN = reduce_plan(TARGET, w);
        localparam int NCARRY = PLAN.nfa + PLAN.nha;
        localparam int USED   = 3 * PLAN.nfa + 2 * PLAN.nha;
        localparam int KEEP   = PLAN.height - USED;
        localparam int HA_POS = 3 * PLAN.nfa;

        column_t below;
        column_t carry;
        column_t result;

        if (w == 0)
        begin : g_first
            assign below = '0;
        end
        else
        begin : g_chain
            assign below = g_col[w-1].carry;
        end

        always_comb
        begin
            logic x;
            logic y;
            logic z;
            x = 1'b0;
            y = 1'b0;
            z = 1'b0;
            carry  = '0;
            result = '0;
            // incoming carries sit at the bottom of the column
            for (int k = 0; k < PLAN.cin; k++)
            begin
                result[k] = below[k];
            end
            for (int i = 0; i < PLAN.nfa; i++)
            begin
                x = cols_in[w][3*i];
                y = cols_in[w][3*i + 1];
                z = cols_in[w][3*i + 2];
                result[PLAN.cin + i] = x ^ y ^ z;
                carry[i] = (x & y) | (z & (x ^ y));
            end
            if (PLAN.nha > 0)
            begin
                x = cols_in[w][HA_POS];
                y = cols_in[w][HA_POS + 1];
                result[PLAN.cin + PLAN.nfa] = x ^ y;
                carry[PLAN.nfa] = x & y;
            end
            // untouched bits move up above the new sums
            for (int k = 0; k < KEEP; k++)
            begin
                result[PLAN.cin + NCARRY + k] = cols_in[w][USED + k];
            end
        end

        assign cols_out[w] = result;
    end

endmodule

// ==== hdl/dadda_tree.sv ====
`timescale 1ns/1ps

module dadda_tree #(
    parameter int FIRST = 0,
    parameter int LAST  = mul_pkg::NUM_STAGES - 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_in,
    input  mul_pkg::col_matrix_t cols_in,
    output logic                 valid_out,
    output mul_pkg::col_matrix_t cols_out
);
    import mul_pkg::*;

    // combinational chain of reduction steps FIRST .. LAST
    for (genvar s = FIRST; s <= LAST; s++)
    begin : g_step
        col_matrix_t stage_in;
        col_matrix_t stage_out;

        if (s == FIRST)
        begin : g_head
            assign stage_in = cols_in;
        end
        else
        begin : g_link
            assign stage_in = g_step[s-1].stage_out;
        end

        dadda_stage #(
            .TARGET(DADDA_HEIGHTS[s])
        ) reduce (
            .cols_in(stage_in),
            .cols_out(stage_out)
        );
    end

    // matrix moves every cycle, valid only marks real data
    always_ff @(posedge clk)
    begin
        cols_out <= g_step[LAST].stage_out;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_out <= 1'b0;
        end
        else
        begin
            valid_out <= valid_in;
        end
    end

endmodule

// ==== hdl/final_adder.sv ====
`timescale 1ns/1ps

module final_adder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_in,
    input  mul_pkg::col_matrix_t cols_in,
    output logic                 out_valid,
    output mul_pkg::half_t       hi,
    output mul_pkg::half_t       lo
);
    import mul_pkg::*;

    half_t row0_lo;
    half_t row1_lo;
    half_t row0_hi;
    half_t row1_hi;
    half_t lo_sum;
    half_t hi_sum;
    logic  lo_carry;

    // two rows from positions 0 and 1 of every column
    always_comb
    begin
        row0_hi = '0;
        row1_hi = '0;
        for (int w = 0; w < OP_W; w++)
        begin
            row0_lo[w] = cols_in[w][0];
            row1_lo[w] = cols_in[w][1];
        end
        // top bit of the high rows stays zero, it only gets a carry
        for (int w = OP_W; w < NUM_COLS; w++)
        begin
            row0_hi[w - OP_W] = cols_in[w][0];
            row1_hi[w - OP_W] = cols_in[w][1];
        end
    end

    assign {lo_carry, lo_sum} = {1'b0, row0_lo} + {1'b0, row1_lo};

    // carry out of the low half feeds the high half
    assign hi_sum = row0_hi + row1_hi + {{(OP_W-1){1'b0}}, lo_carry};

    always_ff @(posedge clk)
    begin
        hi <= hi_sum;
        lo <= lo_sum;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= valid_in;
        end
    end

endmodule

// ==== hdl/mul32.sv ====
`timescale 1ns/1ps

module mul32 (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output logic              out_valid,
    output mul_pkg::half_t    hi,
    output mul_pkg::half_t    lo
);
    import mul_pkg::*;

    col_matrix_t pp_cols;
    col_matrix_t upper_cols;
    col_matrix_t lower_cols;
    logic        upper_valid;
    logic        lower_valid;

    partial_products pp_gen (
        .a(a),
        .b(b),
        .cols(pp_cols)
    );

    // heights 28 down to 6, then register
    dadda_tree #(
        .FIRST(0),
        .LAST(SPLIT_STAGE)
    ) upper_tree (
        .clk(clk),
        .rst(rst),
        .valid_in(in_valid),
        .cols_in(pp_cols),
        .valid_out(upper_valid),
        .cols_out(upper_cols)
    );

    // heights 4 down to 2, then register
    dadda_tree #(
        .FIRST(SPLIT_STAGE + 1),
        .LAST(NUM_STAGES - 1)
    ) lower_tree (
        .clk(clk),
        .rst(rst),
        .valid_in(upper_valid),
        .cols_in(upper_cols),
        .valid_out(lower_valid),
        .cols_out(lower_cols)
    );

    final_adder final_add (
        .clk(clk),
        .rst(rst),
        .valid_in(lower_valid),
        .cols_in(lower_cols),
        .out_valid(out_valid),
        .hi(hi),
        .lo(lo)
    );

endmodule

// ==== hdl/mul_pkg.sv ====
package mul_pkg;

    // operand and product widths
    localparam int OP_W   = 32;
    localparam int PROD_W = 2 * OP_W;

    // weight columns 0 .. PROD_W-2; bit PROD_W-1 only ever comes from a carry
    localparam int NUM_COLS = PROD_W - 1;

    // tallest column of the AND array (weight OP_W-1)
    localparam int MAX_HEIGHT = OP_W;

    // Dadda height sequence, one entry per reduction step
    localparam int NUM_STAGES = 8;
    localparam int DADDA_HEIGHTS [NUM_STAGES] = '{28, 19, 13, 9, 6, 4, 3, 2};

    // last step before the first pipeline register (height 6)
    localparam int SPLIT_STAGE = 4;

    typedef logic [OP_W-1:0] operand_t;

    // one half of the product, hi or lo
    typedef logic [OP_W-1:0] half_t;

    // bits of one weight column, stacked from position 0, unused positions zero
    typedef logic [MAX_HEIGHT-1:0] column_t;

    typedef column_t [NUM_COLS-1:0] col_matrix_t;

endpackage

// ==== hdl/partial_products.sv ====
`timescale 1ns/1ps

module partial_products (
    input  mul_pkg::operand_t    a,
    input  mul_pkg::operand_t    b,
    output mul_pkg::col_matrix_t cols
);
    import mul_pkg::*;

    for (genvar w = 0; w < NUM_COLS; w++)
    begin : g_col
        // lowest b index that lands in this column
        localparam int LOW    = (w < OP_W) ? 0 : w - OP_W + 1;
        localparam int HEIGHT = (w < OP_W) ? w + 1 : PROD_W - 1 - w;

        column_t col;

        always_comb
        begin
            col = '0;
            // position k holds a[w-j] & b[j] with j = LOW + k
            for (int k = 0; k < HEIGHT; k++)
            begin
                col[k] = a[w - LOW - k] & b[LOW + k];
            end
        end

        assign cols[w] = col;
    end

endmodule

// ==== sources.f ====
+incdir+bench
hdl/mul_pkg.sv
hdl/partial_products.sv
hdl/dadda_stage.sv
hdl/dadda_tree.sv
hdl/final_adder.sv
hdl/mul32.sv
bench/tb_mul32.sv
